// File: mem_engine.f
source/mem_engine_pkg.sv
source/ram_port_if.sv
source/ram_singleport.sv
source/mem_cmd_sequencer.sv
source/rsp_fifo.sv
source/mem_engine_top.sv
sim/tb_mem_engine.sv

// File: sim/tb_mem_engine.sv
/* testbench for the memory engine
   random commands against a reference memory model, in-order response scoreboard */
`timescale 1ns/1ps

module tb_mem_engine;

	import mem_engine_pkg::*;

	localparam int ADDR_WIDTH = 8;
	localparam int DATA_WIDTH = 16;
	localparam int MEM_SIZE   = 1 << ADDR_WIDTH;
	localparam int CLK_PERIOD = 10;

	// commands per phase
	localparam int N_WR_RD = 160;
	localparam int N_ADD   = 120;
	localparam int N_FILL  = 120;
	localparam int N_BP    = 200;
	localparam int NUM_CMDS = N_WR_RD + N_ADD + N_FILL + N_BP;

	localparam int MAX_FILL = 12;
	// rsp_ready low for BP_LOW out of every BP_PERIOD cycles
	localparam int BP_PERIOD = 48;
	localparam int BP_LOW    = 32;
	// cycles allowed for the last responses once rsp_ready stays high
	localparam int DRAIN_LIMIT = 64;
	localparam int LIMIT_CYCLES = NUM_CMDS * (MAX_FILL + BP_LOW + 4) + DRAIN_LIMIT + 500;

	logic                      clk;
	logic                      reset;
	logic                      cmd_valid;
	logic                      cmd_ready;
	mem_op_t                   cmd_op;
	logic [ADDR_WIDTH-1:0]     cmd_addr;
	logic [DATA_WIDTH-1:0]     cmd_data;
	logic [FILL_LEN_WIDTH-1:0] cmd_len;
	logic                      rsp_valid;
	logic                      rsp_ready;
	logic [DATA_WIDTH-1:0]     rsp_data;

	integer seed = 32'hf719_2b55;

	// reference model and scoreboard
	logic [DATA_WIDTH-1:0] model_mem [0:MEM_SIZE-1];
	logic [DATA_WIDTH-1:0] exp_q [$];
	int rsp_count = 0;
	int ret_cmds  = 0;

	// command currently offered
	logic                      cur_valid = 1'b0;
	mem_op_t                   cur_op    = OP_WRITE;
	logic [ADDR_WIDTH-1:0]     cur_addr  = '0;
	logic [DATA_WIDTH-1:0]     cur_data  = '0;
	logic [FILL_LEN_WIDTH-1:0] cur_len   = '0;
	logic                      accepted;

	// 0 mostly ready, 1 back-pressure pattern, 2 always ready
	int rsp_mode = 0;
	int bp_tick  = 0;
	logic                  waiting = 1'b0;
	logic [DATA_WIDTH-1:0] held_data;

	mem_engine_top #(
		.ADDR_WIDTH (ADDR_WIDTH),
		.DATA_WIDTH (DATA_WIDTH),
		.RSP_DEPTH  (4)
	) DUT (
		.clk       (clk),
		.reset     (reset),
		.cmd_valid (cmd_valid),
		.cmd_ready (cmd_ready),
		.cmd_op    (cmd_op),
		.cmd_addr  (cmd_addr),
		.cmd_data  (cmd_data),
		.cmd_len   (cmd_len),
		.rsp_valid (rsp_valid),
		.rsp_ready (rsp_ready),
		.rsp_data  (rsp_data)
	);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	// ------------------------------------------------------------
	// helpers
	// ------------------------------------------------------------
	task automatic stop_with_error(input string msg);
		$display("%s", msg);
		$display("Something failed");
		$fatal(1, "stopping at first error");
	endtask

	task automatic check_value(input string name, input logic [31:0] got,
			input logic [31:0] expected);
		if (got !== expected) begin
			stop_with_error($sformatf("CHECK FAILED %s got 0x%h expected 0x%h",
				name, got, expected));
		end
	endtask

	function automatic int unsigned rand_below(input int unsigned n);
		return $unsigned($random(seed)) % n;
	endfunction

	// small window across the top of memory so fills wrap and accesses collide
	function automatic logic [ADDR_WIDTH-1:0] rand_addr();
		return ADDR_WIDTH'(MEM_SIZE - 8 + rand_below(16));
	endfunction

	task automatic apply_model();
		logic [ADDR_WIDTH-1:0] fill_addr;
		case (cmd_op)
			OP_WRITE: model_mem[cmd_addr] = cmd_data;
			OP_READ: begin
				exp_q.push_back(model_mem[cmd_addr]);
				ret_cmds++;
			end
			OP_ADD: begin
				exp_q.push_back(model_mem[cmd_addr]);
				model_mem[cmd_addr] = model_mem[cmd_addr] + cmd_data;
				ret_cmds++;
			end
			default: begin
				fill_addr = cmd_addr;
				repeat (cmd_len) begin
					model_mem[fill_addr] = cmd_data;
					fill_addr = fill_addr + 1'b1;
				end
			end
		endcase
	endtask

	// outputs only move at rising edges and are settled here
	task automatic sample_response();
		if (waiting) begin
			check_value("rsp_valid while stalled", rsp_valid, 1);
			check_value("rsp_data while stalled", rsp_data, held_data);
		end
		waiting = 1'b0;
		if (rsp_valid) begin
			if (exp_q.size() == 0) begin
				stop_with_error("response offered while no read or add is outstanding");
			end
			if (rsp_ready) begin
				check_value("rsp_data", rsp_data, exp_q.pop_front());
				rsp_count++;
			end else begin
				waiting   = 1'b1;
				held_data = rsp_data;
			end
		end
	endtask

	// drive on the falling edge and look at what the next rising edge takes
	task automatic step_cycle();
		@(negedge clk);
		cmd_valid = cur_valid;
		cmd_op    = cur_op;
		cmd_addr  = cur_addr;
		cmd_data  = cur_data;
		cmd_len   = cur_len;
		if (rsp_mode == 2) begin
			rsp_ready = 1'b1;
		end else if (rsp_mode == 1) begin
			bp_tick++;
			rsp_ready = ((bp_tick % BP_PERIOD) >= BP_LOW) ? rand_below(2) : 1'b0;
		end else begin
			rsp_ready = (rand_below(4) != 0);
		end
		#1;
		sample_response();
		accepted = cmd_valid && cmd_ready;
		if (accepted) begin
			apply_model();
		end
	endtask

	task automatic offer_command(input mem_op_t op, input logic [ADDR_WIDTH-1:0] addr,
			input logic [DATA_WIDTH-1:0] data, input logic [FILL_LEN_WIDTH-1:0] len);
		int gap;
		gap = (rand_below(4) == 0) ? rand_below(3) + 1 : 0;
		cur_valid = 1'b0;
		repeat (gap) step_cycle();
		cur_valid = 1'b1;
		cur_op    = op;
		cur_addr  = addr;
		cur_data  = data;
		cur_len   = len;
		// held until taken
		accepted = 1'b0;
		while (!accepted) step_cycle();
		cur_valid = 1'b0;
	endtask

	// mix 0 write/read, 1 adds, 2 fills, 3 everything
	task automatic run_phase(input int count, input int mix);
		int r;
		mem_op_t op;
		logic [FILL_LEN_WIDTH-1:0] len;
		repeat (count) begin
			r = rand_below(8);
			case (mix)
				0: op = (r < 4) ? OP_WRITE : OP_READ;
				1: op = (r < 4) ? OP_ADD : ((r < 7) ? OP_READ : OP_WRITE);
				2: op = (r < 3) ? OP_FILL : ((r < 6) ? OP_READ : OP_WRITE);
				default: op = mem_op_t'(r[1:0]);
			endcase
			len = (rand_below(6) == 0) ? '0 : FILL_LEN_WIDTH'(rand_below(MAX_FILL + 1));
			offer_command(op, rand_addr(), DATA_WIDTH'($random(seed)), len);
		end
	endtask

	// ------------------------------------------------------------
	// main sequence
	// ------------------------------------------------------------
	initial begin
		int drain_left;
		for (int i = 0; i < MEM_SIZE; i++) begin
			model_mem[i] = '0;
		end
		reset     = 1'b1;
		cmd_valid = 1'b0;
		cmd_op    = OP_WRITE;
		cmd_addr  = '0;
		cmd_data  = '0;
		cmd_len   = '0;
		rsp_ready = 1'b0;

		repeat (10) begin
			@(negedge clk);
			check_value("cmd_ready in reset", cmd_ready, 0);
			check_value("rsp_valid in reset", rsp_valid, 0);
		end
		reset = 1'b0;

		// nothing may come back while idle
		repeat (5) step_cycle();

		run_phase(N_WR_RD, 0);
		run_phase(N_ADD, 1);
		run_phase(N_FILL, 2);
		rsp_mode = 1;
		run_phase(N_BP, 3);

		// bounded wait for the responses still owed
		rsp_mode   = 2;
		drain_left = DRAIN_LIMIT;
		while ((exp_q.size() != 0) && (drain_left > 0)) begin
			step_cycle();
			drain_left--;
		end
		repeat (10) step_cycle();

		check_value("response count", rsp_count, ret_cmds);
		$display("Everything OK");
		$finish;
	end

	initial begin
		#(LIMIT_CYCLES * CLK_PERIOD);
		stop_with_error("timeout, the run did not complete within the time limit");
	end

endmodule

// File: source/mem_cmd_sequencer.sv
/* command sequencer for the memory engine
   decodes commands, drives the RAM port, runs fills and adds, books response slots */
`timescale 1ns/1ps

module mem_cmd_sequencer #(
	parameter int ADDR_WIDTH = 8,
	parameter int DATA_WIDTH = 16
) (
	input  logic                                     clk,
	input  logic                                     reset,

	input  logic                                     cmd_valid,
	output logic                                     cmd_ready,
	input  mem_engine_pkg::mem_op_t                  cmd_op,
	input  logic [ADDR_WIDTH-1:0]                    cmd_addr,
	input  logic [DATA_WIDTH-1:0]                    cmd_data,
	input  logic [mem_engine_pkg::FILL_LEN_WIDTH-1:0] cmd_len,

	ram_port_if.ctrl                                 mem,

	output logic                                     reserve,
	input  logic                                     has_room,
	output logic                                     push,
	output logic [DATA_WIDTH-1:0]                    push_data
);

	import mem_engine_pkg::*;

	seq_state_t state;

	// low during reset and for the first cycle after it
	logic active;

	// RAM read started last cycle, its dout goes to the FIFO now
	logic pending_push;

	logic needs_slot;
	logic accept;

	// held operands for multi-cycle commands
	logic [ADDR_WIDTH-1:0]     hold_addr;
	logic [DATA_WIDTH-1:0]     hold_data;
	logic [FILL_LEN_WIDTH-1:0] remaining;

	// ------------------------------------------------------------
	// command handshake
	// ------------------------------------------------------------

	// reads and adds return a word, so they need a FIFO slot
	assign needs_slot = (cmd_op == OP_READ) || (cmd_op == OP_ADD);

	assign cmd_ready = active && (state == ST_IDLE) && (!needs_slot || has_room);
	assign accept    = cmd_valid && cmd_ready;
	assign reserve   = accept && needs_slot;

	// read result is on dout one cycle after the enabled edge
	assign push      = pending_push;
	assign push_data = mem.dout;

	// ------------------------------------------------------------
	// RAM port
	// ------------------------------------------------------------
	always_comb begin
		mem.en   = 1'b0;
		mem.we   = 1'b0;
		mem.addr = cmd_addr;
		mem.din  = cmd_data;

		case (state)
			ST_IDLE: begin
				// fills only write from ST_FILL
				if (accept && (cmd_op != OP_FILL)) begin
					mem.en = 1'b1;
					mem.we = (cmd_op == OP_WRITE);
				end
			end
			ST_ADD_WB: begin
				// dout still holds the old word, sum wraps at the data width
				mem.en   = 1'b1;
				mem.we   = 1'b1;
				mem.addr = hold_addr;
				mem.din  = mem.dout + hold_data;
			end
			ST_FILL: begin
				mem.en   = 1'b1;
				mem.we   = 1'b1;
				mem.addr = hold_addr;
				mem.din  = hold_data;
			end
			default: begin
				mem.en = 1'b0;
			end
		endcase
	end

	// ------------------------------------------------------------
	// control state
	// ------------------------------------------------------------
	always_ff @(posedge clk) begin
		if (reset) begin
			active       <= 1'b0;
			state        <= ST_IDLE;
			pending_push <= 1'b0;
		end else begin
			active       <= 1'b1;
			pending_push <= reserve;

			case (state)
				ST_IDLE: begin
					if (accept && (cmd_op == OP_ADD)) begin
						state <= ST_ADD_WB;
					end else if (accept && (cmd_op == OP_FILL) && (cmd_len != '0)) begin
						state <= ST_FILL;
					end
				end
				ST_ADD_WB: begin
					state <= ST_IDLE;
				end
				ST_FILL: begin
					// last write of the run
					if (remaining == FILL_LEN_WIDTH'(1)) begin
						state <= ST_IDLE;
					end
				end
				default: begin
					state <= ST_IDLE;
				end
			endcase
		end
	end

	// operands, captured at accept and stepped during a fill
	always_ff @(posedge clk) begin
		if ((state == ST_IDLE) && accept) begin
			hold_addr <= cmd_addr;
			hold_data <= cmd_data;
			remaining <= cmd_len;
		end else if (state == ST_FILL) begin
			// address wraps at the top of memory
			hold_addr <= hold_addr + 1'b1;
			remaining <= remaining - 1'b1;
		end
	end

	// ------------------------------------------------------------
	// checks
	// ------------------------------------------------------------
	a_reserve_room: assert property (
		@(posedge clk) disable iff (reset) reserve |-> has_room
	) else $error("slot reserved while FIFO has no room");

	a_push_after_reserve: assert property (
		@(posedge clk) disable iff (reset) push == $past(reserve)
	) else $error("push does not follow reserve by one cycle");

endmodule

// File: source/mem_engine_pkg.sv
/* memory engine shared types
   opcodes, sequencer states and the fixed fill-length width */
package mem_engine_pkg;

	// ------------------------------------------------------------
	// command opcodes
	// ------------------------------------------------------------
	typedef enum logic [1:0] {
		// single word write
		OP_WRITE = 2'd0,
		// single word read, result returned
		OP_READ  = 2'd1,
		// add to stored word, old value returned
		OP_ADD   = 2'd2,
		// write one value over a run of addresses
		OP_FILL  = 2'd3
	} mem_op_t;

	// ------------------------------------------------------------
	// sequencer states
	// ------------------------------------------------------------
	typedef enum logic [1:0] {
		// decoding commands, single-cycle accesses
		ST_IDLE   = 2'd0,
		// write-back half of an add
		ST_ADD_WB = 2'd1,
		// one write per cycle until the count runs out
		ST_FILL   = 2'd2
	} seq_state_t;

	// fill length field
	localparam int FILL_LEN_WIDTH = 8;

endpackage

// File: source/mem_engine_top.sv
/* memory engine top level
   command sequencer, single-port RAM and response FIFO */
`timescale 1ns/1ps

module mem_engine_top #(
	parameter int ADDR_WIDTH = 8,
	parameter int DATA_WIDTH = 16,
	parameter int RSP_DEPTH  = 4
) (
	input  logic                                     clk,
	input  logic                                     reset,

	// command channel
	input  logic                                     cmd_valid,
	output logic                                     cmd_ready,
	input  mem_engine_pkg::mem_op_t                  cmd_op,
	input  logic [ADDR_WIDTH-1:0]                    cmd_addr,
	input  logic [DATA_WIDTH-1:0]                    cmd_data,
	input  logic [mem_engine_pkg::FILL_LEN_WIDTH-1:0] cmd_len,

	// response channel
	output logic                                     rsp_valid,
	input  logic                                     rsp_ready,
	output logic [DATA_WIDTH-1:0]                    rsp_data
);

	// sequencer to FIFO
	logic                  reserve;
	logic                  has_room;
	logic                  push;
	logic [DATA_WIDTH-1:0] push_data;

	ram_port_if #(
		.ADDR_WIDTH (ADDR_WIDTH),
		.DATA_WIDTH (DATA_WIDTH)
	) ram_bus ();

	mem_cmd_sequencer #(
		.ADDR_WIDTH (ADDR_WIDTH),
		.DATA_WIDTH (DATA_WIDTH)
	) u_sequencer (
		.clk       (clk),
		.reset     (reset),
		.cmd_valid (cmd_valid),
		.cmd_ready (cmd_ready),
		.cmd_op    (cmd_op),
		.cmd_addr  (cmd_addr),
		.cmd_data  (cmd_data),
		.cmd_len   (cmd_len),
		.mem       (ram_bus.ctrl),
		.reserve   (reserve),
		.has_room  (has_room),
		.push      (push),
		.push_data (push_data)
	);

	ram_singleport #(
		.ADDR_WIDTH (ADDR_WIDTH),
		.DATA_WIDTH (DATA_WIDTH)
	) u_ram (
		.clk (clk),
		.mem (ram_bus.ram)
	);

	rsp_fifo #(
		.DATA_WIDTH (DATA_WIDTH),
		.RSP_DEPTH  (RSP_DEPTH)
	) u_rsp_fifo (
		.clk       (clk),
		.reset     (reset),
		.reserve   (reserve),
		.has_room  (has_room),
		.push      (push),
		.push_data (push_data),
		.rsp_valid (rsp_valid),
		.rsp_ready (rsp_ready),
		.rsp_data  (rsp_data)
	);

endmodule

// File: source/ram_port_if.sv
/* single RAM port bundle between the command sequencer and the RAM */
`timescale 1ns/1ps

interface ram_port_if #(
	parameter int ADDR_WIDTH = 8,
	parameter int DATA_WIDTH = 16
) ();

	// access strobe and direction
	logic                  en;
	logic                  we;

	logic [ADDR_WIDTH-1:0] addr;
	logic [DATA_WIDTH-1:0] din;

	// word held before the last enabled edge
	logic [DATA_WIDTH-1:0] dout;

	modport ctrl (
		output en,
		output we,
		output addr,
		output din,
		input  dout
	);

	modport ram (
		input  en,
		input  we,
		input  addr,
		input  din,
		output dout
	);

endinterface

// File: source/ram_singleport.sv
/* single-port block RAM, read-first, with clock enable
   contents start at zero, output register moves only on enabled edges */
`timescale 1ns/1ps

module ram_singleport #(
	parameter int ADDR_WIDTH = 8,
	parameter int DATA_WIDTH = 16
) (
	input logic     clk,
	ram_port_if.ram mem
);

	localparam int MEM_SIZE = 1 << ADDR_WIDTH;

	logic [DATA_WIDTH-1:0] mem_array [0:MEM_SIZE-1];

	// ------------------------------------------------------------
	// storage
	// ------------------------------------------------------------
	always @(posedge clk) begin
		if (mem.en && mem.we) begin
			mem_array[mem.addr] <= mem.din;
		end
	end

	// read-first: dout gets the word from before this edge's write
	always_ff @(posedge clk) begin
		if (mem.en) begin
			mem.dout <= mem_array[mem.addr];
		end
	end

	// start-up contents
	initial begin
		for (int i = 0; i < MEM_SIZE; i++) begin
			mem_array[i] = '0;
		end
	end

	// ------------------------------------------------------------
	// checks
	// ------------------------------------------------------------

	// address comes from the sequencer, must be clean on any access
	a_addr_known: assert property (
		@(posedge clk) mem.en |-> !$isunknown(mem.addr)
	) else $error("RAM accessed with unknown address");

endmodule

// File: source/rsp_fifo.sv
/* in-order response FIFO, slots are booked when a read starts
   and filled one cycle later when the read data arrives */
`timescale 1ns/1ps

module rsp_fifo #(
	parameter int DATA_WIDTH = 16,
	parameter int RSP_DEPTH  = 4
) (
	input  logic                  clk,
	input  logic                  reset,

	input  logic                  reserve,
	output logic                  has_room,
	input  logic                  push,
	input  logic [DATA_WIDTH-1:0] push_data,

	output logic                  rsp_valid,
	input  logic                  rsp_ready,
	output logic [DATA_WIDTH-1:0] rsp_data
);

	localparam int PTR_W = $clog2(RSP_DEPTH);
	localparam int CNT_W = $clog2(RSP_DEPTH + 1);

	logic [DATA_WIDTH-1:0] buffer [0:RSP_DEPTH-1];

	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;

	// entries holding data, and entries booked for reads in flight
	logic [CNT_W-1:0] stored_cnt;
	logic [CNT_W-1:0] resv_cnt;

	logic pop;

	// ------------------------------------------------------------
	// response side
	// ------------------------------------------------------------
	assign rsp_valid = (stored_cnt != '0);
	assign rsp_data  = buffer[rd_ptr];
	assign pop       = rsp_valid && rsp_ready;

	// booked slots count as used
	assign has_room  = (CNT_W'(stored_cnt + resv_cnt) < RSP_DEPTH);

	// ------------------------------------------------------------
	// pointers and counts
	// ------------------------------------------------------------
	always_ff @(posedge clk) begin
		if (reset) begin
			wr_ptr     <= '0;
			rd_ptr     <= '0;
			stored_cnt <= '0;
			resv_cnt   <= '0;
		end else begin
			if (push) begin
				wr_ptr <= (wr_ptr == PTR_W'(RSP_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
			end
			if (pop) begin
				rd_ptr <= (rd_ptr == PTR_W'(RSP_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
			end

			stored_cnt <= stored_cnt + CNT_W'(push) - CNT_W'(pop);
			// push turns one booking into a stored entry
			resv_cnt   <= resv_cnt + CNT_W'(reserve) - CNT_W'(push);
		end
	end

	always_ff @(posedge clk) begin
		if (push) begin
			buffer[wr_ptr] <= push_data;
		end
	end

	// ------------------------------------------------------------
	// checks
	// ------------------------------------------------------------
	a_push_booked: assert property (
		@(posedge clk) disable iff (reset) push |-> (resv_cnt != '0)
	) else $error("push without an outstanding reservation");

	a_no_overflow: assert property (
		@(posedge clk) disable iff (reset) stored_cnt <= RSP_DEPTH
	) else $error("response FIFO holds more than RSP_DEPTH entries");

endmodule
